/* flist.f */
common/img_pkg.sv
common/pix_if.sv
src/frame_decoder.sv
capture/capture_ctrl.sv
capture/pixel_stats.sv
src/frame_buffer.sv
src/img_controller.sv
dv/img_controller_tb.sv

/* Bender.yml */
package:
  name: img_controller

sources:
  - common/img_pkg.sv
  - common/pix_if.sv
  - src/frame_decoder.sv
  - capture/capture_ctrl.sv
  - capture/pixel_stats.sv
  - src/frame_buffer.sv
  - src/img_controller.sv
  - target: test
    files:
      - dv/img_controller_tb.sv

/* dv/img_controller_tb.sv */
`timescale 1ns/1ps

module img_controller_tb;

    localparam int HEADER_WIDTH = 128;
    localparam int HDR_WORDS    = HEADER_WIDTH / 16;

    logic                    clk;
    logic                    fifoIn_rst;
    logic                    cmd_capture;
    logic                    cmd_readout;
    logic [HEADER_WIDTH-1:0] cmd_header;
    logic                    readout_ready;
    logic                    readout_trigger;
    logic [15:0]             readout_data;
    logic                    capture_done;
    logic [12:0]             capture_pixel_count;
    logic [17:0]             capture_highlight_count;
    logic [17:0]             capture_shadow_count;
    logic [11:0]             img_d;
    logic                    img_fv;
    logic                    img_lv;

    // Reference model of expected buffer words and stats
    logic [15:0] exp_q[$];
    int          exp_hi;
    int          exp_sh;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          done_count;

    img_controller img_controller_i (.*);

    always #50 clk = ~clk;

    // Count capture_done pulses away from the active edge
    always @(negedge clk) begin
        if (capture_done) done_count++;
    end

    // ============================================================
    // Protocol checks
    // ============================================================

    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        capture_done |=> !capture_done)
        else begin
            $display("capture_done stayed high for more than one cycle");
            errors++;
        end

    // Stalled readout must hold its word
    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (readout_ready && !readout_trigger) |=> $stable(readout_data))
        else begin
            $display("FAIL readout_data: 0x%h -> 0x%h while stalled",
                     $past(readout_data), readout_data);
            errors++;
        end

    // ============================================================
    // Helpers
    // ============================================================

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // Fresh model and random header with a one-cycle capture strobe
    task automatic arm_capture();
        logic [HEADER_WIDTH-1:0] hdr;
        hdr = {$urandom(), $urandom(), $urandom(), $urandom()};
        exp_q.delete();
        exp_hi = 0;
        exp_sh = 0;
        // Most significant word goes first
        for (int i = HDR_WORDS - 1; i >= 0; i--) exp_q.push_back(hdr[i*16 +: 16]);
        cmd_header  = hdr;
        cmd_capture = 1'b1;
        step_clock();
        cmd_capture = 1'b0;
    endtask

    // Sensor model with a front porch that covers the header writes
    task automatic send_frame(input int lines, input int ppl, input bit force_stats,
                              input bit record);
        logic [11:0] px;
        bit          sample;
        img_fv = 1'b1;
        repeat (12) step_clock();
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < ppl; p++) begin
                px     = 12'($urandom);
                // Grid point when line and pixel are both at phase 0
                sample = (l % 4 == 0) && (p % 4 == 0);
                // Uneven mix of highlight and shadow points
                if (force_stats && sample) begin
                    if (((l / 4) + (p / 4)) % 3 != 0) px[11:5] = 7'h7f;
                    else                              px[11:5] = 7'h00;
                end
                img_lv = 1'b1;
                img_d  = px;
                if (record) begin
                    exp_q.push_back({4'h0, px});
                    if (sample && px[11:5] == 7'h7f) exp_hi++;
                    else if (sample && px[11:5] == 7'h00) exp_sh++;
                end
                step_clock();
            end
            // Line blanking
            img_lv = 1'b0;
            repeat (3) step_clock();
        end
        repeat (2) step_clock();
        img_fv = 1'b0;
        repeat (4) step_clock();
    endtask

    task automatic wait_done(input int limit);
        bit seen;
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < limit) begin
            @(negedge clk);
            if (capture_done) seen = 1'b1;
            n++;
        end
        if (!seen) begin
            $display("timeout waiting for capture_done");
            errors++;
        end
    endtask

    // Drain the buffer and compare against the model queue
    task automatic read_out(input bit gaps);
        int n;
        cmd_readout = 1'b1;
        step_clock();
        cmd_readout = 1'b0;
        n = 0;
        while (!readout_ready && n < 10) begin
            step_clock();
            n++;
        end
        if (!readout_ready) begin
            $display("timeout waiting for readout_ready");
            errors++;
        end
        n = 0;
        while (exp_q.size() > 0 && n < 2000) begin
            readout_trigger = gaps ? ($urandom() % 3 != 0) : 1'b1;
            @(negedge clk);
            if (!readout_ready) begin
                $display("readout_ready fell with %0d words left", exp_q.size());
                errors++;
                break;
            end
            if (readout_trigger) begin
                check_eq("readout_data", readout_data, exp_q[0]);
                void'(exp_q.pop_front());
            end
            step_clock();
            n++;
        end
        readout_trigger = 1'b0;
        if (exp_q.size() > 0) begin
            $display("readout did not finish, %0d words left", exp_q.size());
            errors++;
        end
        check_eq("readout_ready", readout_ready, 1'b0);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        int err0;
        int done0;
        void'($urandom(69832));
        clk             = 1'b0;
        fifoIn_rst      = 1'b0;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_header      = '0;
        readout_trigger = 1'b0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        done_count      = 0;
        repeat (5) step_clock();
        fifoIn_rst = 1'b1;
        step_clock();

        // Idle state after reset
        err0 = errors;
        check_eq("readout_ready", readout_ready, 1'b0);
        check_eq("capture_done", capture_done, 1'b0);
        check_eq("capture_pixel_count", capture_pixel_count, 0);
        check_eq("capture_highlight_count", capture_highlight_count, 0);
        check_eq("capture_shadow_count", capture_shadow_count, 0);
        report_test("reset", err0);

        // Plain 6x10 capture with forced grid values
        err0  = errors;
        done0 = done_count;
        arm_capture();
        repeat (3) step_clock();
        fork
            send_frame(6, 10, 1'b1, 1'b1);
            wait_done(400);
        join
        repeat (4) step_clock();
        check_eq("capture_done pulses", done_count - done0, 1);
        check_eq("capture_pixel_count", capture_pixel_count, HDR_WORDS + 60);
        report_test("capture 6x10", err0);

        err0 = errors;
        check_eq("capture_highlight_count", capture_highlight_count, exp_hi);
        check_eq("capture_shadow_count", capture_shadow_count, exp_sh);
        report_test("stats", err0);

        err0 = errors;
        read_out(1'b0);
        report_test("readout", err0);

        // Arm in the middle of a frame so that the next frame is stored
        err0  = errors;
        done0 = done_count;
        fork
            send_frame(6, 10, 1'b0, 1'b0);
            begin
                repeat (30) step_clock();
                arm_capture();
            end
        join
        fork
            send_frame(5, 8, 1'b1, 1'b1);
            wait_done(400);
        join
        repeat (4) step_clock();
        check_eq("capture_done pulses", done_count - done0, 1);
        check_eq("capture_pixel_count", capture_pixel_count, HDR_WORDS + 40);
        check_eq("capture_highlight_count", capture_highlight_count, exp_hi);
        check_eq("capture_shadow_count", capture_shadow_count, exp_sh);
        report_test("mid-frame arm", err0);

        err0 = errors;
        read_out(1'b1);
        report_test("readout with gaps", err0);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src/img_controller.sv */
`timescale 1ns/1ps

module img_controller
    import img_pkg::*;
#(
    parameter  int HEADER_WIDTH    = 128,
    parameter  int IMAGE_WORDS_MAX = 4096,
    localparam int COUNT_WIDTH     = $clog2(IMAGE_WORDS_MAX + 1),
    localparam int ADDR_WIDTH      = $clog2(IMAGE_WORDS_MAX)
)(
    input  logic                        clk,
    input  logic                        fifoIn_rst,
    // Commands, single-cycle strobes
    input  logic                        cmd_capture,
    input  logic                        cmd_readout,
    input  logic [HEADER_WIDTH-1:0]     cmd_header,
    // Readout, ready with trigger
    output logic                        readout_ready,
    input  logic                        readout_trigger,
    output logic [WORD_WIDTH-1:0]       readout_data,
    // Capture status
    output logic                        capture_done,
    output logic [COUNT_WIDTH-1:0]      capture_pixel_count,
    output logic [STAT_COUNT_WIDTH-1:0] capture_highlight_count,
    output logic [STAT_COUNT_WIDTH-1:0] capture_shadow_count,
    // Sensor pins
    input  logic [PIXEL_WIDTH-1:0]      img_d,
    input  logic                        img_fv,
    input  logic                        img_lv
);
    // Capture to buffer and stats
    logic                  buf_we;
    logic [ADDR_WIDTH-1:0] buf_addr;
    logic [WORD_WIDTH-1:0] buf_wdata;
    logic                  pixel_write;
    logic                  clear_stats;

    pix_if pix ();

    frame_decoder frame_decoder_i (
        .clk(clk), .fifoIn_rst(fifoIn_rst),
        .img_d(img_d), .img_fv(img_fv), .img_lv(img_lv), .pix(pix.source)
    );

    capture_ctrl #(.HEADER_WIDTH(HEADER_WIDTH), .IMAGE_WORDS_MAX(IMAGE_WORDS_MAX)) capture_ctrl_i (
        .clk(clk), .fifoIn_rst(fifoIn_rst),
        .cmd_capture(cmd_capture), .cmd_header(cmd_header), .pix(pix.capture),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
        .pixel_write(pixel_write), .clear_stats(clear_stats),
        .word_count(capture_pixel_count), .capture_done(capture_done)
    );

    pixel_stats pixel_stats_i (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .pix(pix.stats),
        .pixel_write(pixel_write), .clear_stats(clear_stats),
        .highlight_count(capture_highlight_count), .shadow_count(capture_shadow_count)
    );

    frame_buffer #(.IMAGE_WORDS_MAX(IMAGE_WORDS_MAX)) frame_buffer_i (
        .clk(clk), .fifoIn_rst(fifoIn_rst),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
        .word_count(capture_pixel_count), .cmd_readout(cmd_readout),
        .readout_ready(readout_ready), .readout_trigger(readout_trigger),
        .readout_data(readout_data)
    );

endmodule

/* src/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer
    import img_pkg::*;
#(
    parameter  int IMAGE_WORDS_MAX = 4096,
    localparam int COUNT_WIDTH     = $clog2(IMAGE_WORDS_MAX + 1),
    localparam int ADDR_WIDTH      = $clog2(IMAGE_WORDS_MAX)
)(
    input  logic                   clk,
    input  logic                   fifoIn_rst,
    input  logic                   buf_we,
    input  logic [ADDR_WIDTH-1:0]  buf_addr,
    input  logic [WORD_WIDTH-1:0]  buf_wdata,
    input  logic [COUNT_WIDTH-1:0] word_count,
    input  logic                   cmd_readout,
    output logic                   readout_ready,
    input  logic                   readout_trigger,
    output logic [WORD_WIDTH-1:0]  readout_data
);

    // ============================================================
    // Word memory
    // ============================================================

    logic [WORD_WIDTH-1:0]  mem [IMAGE_WORDS_MAX];

    always_ff @(posedge clk) begin
        if (buf_we) mem[buf_addr] <= buf_wdata;
    end

    // ============================================================
    // Readout sequencer
    // ============================================================

    // Words still to send
    logic [COUNT_WIDTH-1:0] remaining;
    logic [ADDR_WIDTH-1:0]  rd_addr;
    logic                   xfer;

    assign readout_ready = (remaining != '0);
    // Word accepted this cycle
    assign xfer          = readout_ready && readout_trigger;
    // Async read, holds while trigger is low
    assign readout_data  = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            remaining <= '0;
            rd_addr   <= '0;
        end else if (cmd_readout) begin
            // Whole capture, from the header on
            remaining <= word_count;
            rd_addr   <= '0;
        end else if (xfer) begin
            remaining <= remaining - 1'b1;
            rd_addr   <= rd_addr + 1'b1;
        end
    end

endmodule

/* capture/pixel_stats.sv */
`timescale 1ns/1ps

module pixel_stats
    import img_pkg::*;
(
    input  logic                        clk,
    input  logic                        fifoIn_rst,
    pix_if.stats                        pix,
    input  logic                        pixel_write,
    input  logic                        clear_stats,
    output logic [STAT_COUNT_WIDTH-1:0] highlight_count,
    output logic [STAT_COUNT_WIDTH-1:0] shadow_count
);
    // Stage one, stored grid pixel and its top bits
    logic                 sample_q;
    logic [STAT_BITS-1:0] top_q;

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) sample_q <= 1'b0;
        else             sample_q <= pixel_write && pix.stat_sample;
    end

    always_ff @(posedge clk) begin
        top_q <= pix.pixel_data[PIXEL_WIDTH-1 -: STAT_BITS];
    end

    // Stage two, classify and count
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || clear_stats) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (sample_q) begin
            // Mid-tones count nowhere
            if (top_q == HIGHLIGHT_CODE)   highlight_count <= highlight_count + 1'b1;
            else if (top_q == SHADOW_CODE) shadow_count <= shadow_count + 1'b1;
        end
    end

endmodule

/* capture/capture_ctrl.sv */
`timescale 1ns/1ps

module capture_ctrl
    import img_pkg::*;
#(
    parameter  int HEADER_WIDTH    = 128,
    parameter  int IMAGE_WORDS_MAX = 4096,
    localparam int COUNT_WIDTH     = $clog2(IMAGE_WORDS_MAX + 1),
    localparam int ADDR_WIDTH      = $clog2(IMAGE_WORDS_MAX)
)(
    input  logic                    clk,
    input  logic                    fifoIn_rst,
    input  logic                    cmd_capture,
    input  logic [HEADER_WIDTH-1:0] cmd_header,
    pix_if.capture                  pix,
    output logic                    buf_we,
    output logic [ADDR_WIDTH-1:0]   buf_addr,
    output logic [WORD_WIDTH-1:0]   buf_wdata,
    output logic                    pixel_write,
    output logic                    clear_stats,
    output logic [COUNT_WIDTH-1:0]  word_count,
    output logic                    capture_done
);
    localparam int HEADER_WORDS = HEADER_WIDTH / WORD_WIDTH;
    localparam logic [COUNT_WIDTH-1:0] WORDS_MAX    = COUNT_WIDTH'(IMAGE_WORDS_MAX);
    localparam logic [COUNT_WIDTH-1:0] HEADER_COUNT = COUNT_WIDTH'(HEADER_WORDS);
    localparam logic [COUNT_WIDTH-1:0] HEADER_LAST  = COUNT_WIDTH'(HEADER_WORDS - 1);

    cap_state_t              state;
    // Latched header, top word goes out first
    logic [HEADER_WIDTH-1:0] header_sh;
    logic [COUNT_WIDTH-1:0]  wr_addr;
    logic                    room;
    logic                    store_pixel;

    // Buffer still has space
    assign room        = wr_addr < WORDS_MAX;
    assign store_pixel = (state == PIXELS) && pix.pixel_valid && room;

    // ============================================================
    // Buffer write port
    // ============================================================

    assign buf_we      = ((state == HEADER) && room) || store_pixel;
    assign buf_addr    = wr_addr[ADDR_WIDTH-1:0];
    // Header word, else the pixel zero-extended
    assign buf_wdata   = (state == HEADER) ? header_sh[HEADER_WIDTH-1 -: WORD_WIDTH]
                                           : {{(WORD_WIDTH-PIXEL_WIDTH){1'b0}}, pix.pixel_data};
    assign pixel_write = store_pixel;

    always_ff @(posedge clk) begin
        if (cmd_capture)          header_sh <= cmd_header;
        else if (state == HEADER) header_sh <= header_sh << WORD_WIDTH;
    end

    // ============================================================
    // Capture FSM
    // ============================================================

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state        <= IDLE;
            wr_addr      <= '0;
            word_count   <= '0;
            clear_stats  <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            clear_stats  <= 1'b0;
            capture_done <= 1'b0;

            // Header words are counted up front
            if (clear_stats)      word_count <= HEADER_COUNT;
            else if (store_pixel) word_count <= word_count + 1'b1;

            case (state)
            // Skip the rest of any frame already running
            WAIT_INVALID: begin
                if (!pix.frame_valid) state <= WAIT_START;
            end
            WAIT_START: begin
                if (pix.frame_start) begin
                    wr_addr <= '0;
                    state   <= HEADER;
                end
            end
            // One header word per cycle
            HEADER: begin
                if (room) wr_addr <= wr_addr + 1'b1;
                if (wr_addr == HEADER_LAST || !room) state <= PIXELS;
            end
            PIXELS: begin
                if (store_pixel) wr_addr <= wr_addr + 1'b1;
                if (pix.frame_end) begin
                    capture_done <= 1'b1;
                    state        <= IDLE;
                end
            end
            default: state <= IDLE;
            endcase

            // New command wins, also mid-capture
            if (cmd_capture) begin
                clear_stats <= 1'b1;
                state       <= WAIT_INVALID;
            end
        end
    end

endmodule

/* src/frame_decoder.sv */
`timescale 1ns/1ps

module frame_decoder
    import img_pkg::*;
(
    input  logic                   clk,
    input  logic                   fifoIn_rst,
    input  logic [PIXEL_WIDTH-1:0] img_d,
    input  logic                   img_fv,
    input  logic                   img_lv,
    pix_if.source                  pix
);

    // ============================================================
    // Sensor input register stage
    // ============================================================

    logic [PIXEL_WIDTH-1:0] d_q;
    logic                   fv_q;
    logic                   lv_q;
    // Levels one cycle back, for edge detect
    logic                   fv_prev;
    logic                   lv_prev;
    logic                   pixel_valid;
    logic                   line_end;
    // Pixel index in line and line index in frame, both mod 4
    logic [GRID_BITS-1:0]   x_phase;
    logic [GRID_BITS-1:0]   y_phase;

    // Pixel payload
    always_ff @(posedge clk) begin
        d_q <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            fv_prev <= fv_q;
            lv_prev <= lv_q;
        end
    end

    // Line valid only counts inside a frame
    assign pixel_valid = fv_q && lv_q;
    // Falling line valid
    assign line_end    = lv_prev && !lv_q;

    // ============================================================
    // Stats grid phase
    // ============================================================

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            x_phase <= '0;
            y_phase <= '0;
        end else begin
            // Restart at every line
            if (pixel_valid) x_phase <= x_phase + GRID_BITS'(1);
            else             x_phase <= '0;
            // Held at zero between frames
            if (!fv_q)         y_phase <= '0;
            else if (line_end) y_phase <= y_phase + GRID_BITS'(1);
        end
    end

    // Stream outputs, one cycle behind the pins
    assign pix.frame_valid = fv_q;
    assign pix.frame_start = fv_q && !fv_prev;
    assign pix.frame_end   = !fv_q && fv_prev;
    assign pix.pixel_valid = pixel_valid;
    assign pix.pixel_data  = d_q;
    assign pix.stat_sample = pixel_valid && (x_phase == '0) && (y_phase == '0);

endmodule

/* common/pix_if.sv */
`timescale 1ns/1ps

// Decoded sensor stream, decoder to capture and stats
interface pix_if
    import img_pkg::*;
();
    // Registered frame valid level
    logic                   frame_valid;
    // Single-cycle edges of frame_valid
    logic                   frame_start;
    logic                   frame_end;
    // Line valid inside a valid frame
    logic                   pixel_valid;
    logic [PIXEL_WIDTH-1:0] pixel_data;
    // Pixel sits on the stats grid
    logic                   stat_sample;

    modport source (output frame_valid, frame_start, frame_end, pixel_valid,
                    pixel_data, stat_sample);

    modport capture (input frame_valid, frame_start, frame_end, pixel_valid, pixel_data);

    modport stats (input pixel_data, stat_sample);

endinterface

/* common/img_pkg.sv */
package img_pkg;

    // ============================================================
    // Sensor and buffer widths
    // ============================================================

    // Raw sensor pixel
    localparam int PIXEL_WIDTH = 12;

    // Frame buffer and readout word
    localparam int WORD_WIDTH = 16;

    // ============================================================
    // Highlight and shadow statistics
    // ============================================================

    // Pixel high bits that decide highlight or shadow
    localparam int STAT_BITS = 7;

    // Per-frame stat counters
    localparam int STAT_COUNT_WIDTH = 18;

    // Grid phase counters, one sample per 4x4 block
    localparam int GRID_BITS = 2;

    // Top bits saturated high
    localparam logic [STAT_BITS-1:0] HIGHLIGHT_CODE = {STAT_BITS{1'b1}};
    // Top bits all low
    localparam logic [STAT_BITS-1:0] SHADOW_CODE = {STAT_BITS{1'b0}};

    // ============================================================
    // Capture FSM
    // ============================================================

    typedef enum logic [2:0] {
        IDLE,
        WAIT_INVALID,
        WAIT_START,
        HEADER,
        PIXELS
    } cap_state_t;

endpackage
